/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o
);

	localparam realtime HALF_PERIOD = 4.0;  // 8 ns period

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

endmodule

/* bench/usb_interface_tb.sv */
`timescale 1ns/1ps

module usb_interface_tb
	import usb_pkg::*;
();

	localparam int N_RANDOM = 40;
	localparam int N_DUMPS  = 4;
	localparam int MAX_DUMP = 16;
	// Fixed commands outside the random loop stay well under 60
	localparam int N_CMDS      = 2 * N_RANDOM + 60;
	localparam int CYCLE_LIMIT = 40 + 16 * N_CMDS + 12 * N_DUMPS * (MAX_DUMP + 2);

	logic   ftdi_clk;
	logic   reset_i;
	logic   reset_o;
	logic   cmdfifo_rxf_i;
	logic   cmdfifo_txe_i;
	byte_t  cmdfifo_din_i;
	logic   cmdfifo_rd_o;
	logic   cmdfifo_wr_o;
	byte_t  cmdfifo_dout_o;
	logic   cmdfifo_isout_o;
	byte_t  status_i;
	logic   fifo_empty_i;
	byte_t  fifo_data_i;
	logic   fifo_rd_en_o;
	word_t  extclk_frequency_i;
	phase_t phase_i;
	logic   phase_done_i;
	word_t  maxsamples_i;
	byte_t  gain_o;
	logic   hilow_o;
	logic   trigger_mode_o;
	logic   cmd_arm_o;
	logic   trigger_wait_o;
	logic   adc_clk_src_o;
	word_t  trigger_offset_o;
	word_t  maxsamples_o;
	phase_t phase_o;
	logic   phase_ld_o;

	int     seed;
	int     errors;
	int     checks;
	int     cyc;
	int     pop_cyc;
	int     wr_cyc;
	int     ld_pulses;
	int     soft_pulses;
	logic   cmd_pop;
	logic   smp_pop;
	logic   txe_gaps;
	logic   done_pulse;
	logic   rst_v;
	byte_t  host_q[$];  // Host to DUT command bytes
	byte_t  smp_q[$];   // Sample FIFO contents
	byte_t  rx_q[$];    // Bytes the host received
	byte_t  status_v;
	word_t  freq_v;
	phase_t phase_v;
	word_t  maxs_v;

	// Register model
	byte_t  m_gain;
	byte_t  m_settings;
	byte_t  m_echo;
	word_t  m_samples;
	word_t  m_offset;
	phase_t m_phase;
	phase_t m_cap;
	logic   m_done;

	reg_addr_t addr_list [0:11];  // Writable registers, status last

	tb_clock clock_inst (
		.clk_o (ftdi_clk)
	);

	usb_interface usb_interface_inst (
		.ftdi_clk           (ftdi_clk),
		.reset_i            (reset_i),
		.reset_o            (reset_o),
		.cmdfifo_rxf_i      (cmdfifo_rxf_i),
		.cmdfifo_txe_i      (cmdfifo_txe_i),
		.cmdfifo_din_i      (cmdfifo_din_i),
		.cmdfifo_rd_o       (cmdfifo_rd_o),
		.cmdfifo_wr_o       (cmdfifo_wr_o),
		.cmdfifo_dout_o     (cmdfifo_dout_o),
		.cmdfifo_isout_o    (cmdfifo_isout_o),
		.status_i           (status_i),
		.fifo_empty_i       (fifo_empty_i),
		.fifo_data_i        (fifo_data_i),
		.fifo_rd_en_o       (fifo_rd_en_o),
		.extclk_frequency_i (extclk_frequency_i),
		.phase_i            (phase_i),
		.phase_done_i       (phase_done_i),
		.maxsamples_i       (maxsamples_i),
		.gain_o             (gain_o),
		.hilow_o            (hilow_o),
		.trigger_mode_o     (trigger_mode_o),
		.cmd_arm_o          (cmd_arm_o),
		.trigger_wait_o     (trigger_wait_o),
		.adc_clk_src_o      (adc_clk_src_o),
		.trigger_offset_o   (trigger_offset_o),
		.maxsamples_o       (maxsamples_o),
		.phase_o            (phase_o),
		.phase_ld_o         (phase_ld_o)
	);

	// Commit last cycle's pops, drive on the falling edge, then sample
	task automatic tick();
		@(negedge ftdi_clk);
		cyc++;
		if (cmd_pop)
			void'(host_q.pop_front());
		if (smp_pop)
			fifo_data_i = smp_q.pop_front();  // Valid the cycle after the pop
		reset_i            = rst_v;
		cmdfifo_rxf_i      = (host_q.size() != 0);
		cmdfifo_din_i      = cmdfifo_rxf_i ? host_q[0] : 8'h00;
		cmdfifo_txe_i      = txe_gaps ? (($random(seed) & 3) != 0) : 1'b1;
		fifo_empty_i       = (smp_q.size() == 0);
		status_i           = status_v;
		extclk_frequency_i = freq_v;
		phase_i            = phase_v;
		phase_done_i       = done_pulse;
		done_pulse         = 1'b0;
		#1;
		cmd_pop = cmdfifo_rd_o;
		smp_pop = fifo_rd_en_o;
		if (cmdfifo_rd_o)
			pop_cyc = cyc;
		if (cmdfifo_wr_o) begin
			rx_q.push_back(cmdfifo_dout_o);
			wr_cyc = cyc;
		end
		if (phase_ld_o)
			ld_pulses++;
		if (reset_o && !reset_i)
			soft_pulses++;
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic clear_model();
		m_gain     = '0;
		m_settings = '0;
		m_echo     = '0;
		m_samples  = maxs_v;  // Sample count reloads its input
		m_offset   = '0;
		m_phase    = '0;
		m_cap      = '0;
		m_done     = 1'b0;
	endtask

	function automatic byte_t model_read(input reg_addr_t addr);
		int    rs;
		int    ro;
		byte_t val;
		rs  = int'(addr) - int'(SAMPLES_ADDR);
		ro  = int'(addr) - int'(OFFSET_ADDR);
		val = 8'h00;
		case (addr)
			GAIN_ADDR:     val = m_gain;
			SETTINGS_ADDR: val = m_settings;
			STATUS_ADDR:   val = status_v;
			ECHO_ADDR:     val = m_echo;
			PHASE_LO_ADDR: val = m_cap[7:0];
			PHASE_HI_ADDR: val = {6'd0, m_done, m_cap[8]};
			default: begin
				if (rs >= 0 && rs < 4)
					val = m_samples[8*rs +: 8];
				if (ro >= 0 && ro < 4)
					val = m_offset[8*ro +: 8];
			end
		endcase
		return val;
	endfunction

	task automatic write_reg(input reg_addr_t addr, input byte_t data);
		int rs;
		int ro;
		rs = int'(addr) - int'(SAMPLES_ADDR);
		ro = int'(addr) - int'(OFFSET_ADDR);
		host_q.push_back({2'b11, addr});
		host_q.push_back(data);
		while (host_q.size() != 0)
			tick();
		tick();  // Write strobe
		tick();  // Register holds the byte
		case (addr)
			GAIN_ADDR:     m_gain = data;
			SETTINGS_ADDR: m_settings = data;
			ECHO_ADDR:     m_echo = data;
			PHASE_LO_ADDR: m_phase[7:0] = data;
			PHASE_HI_ADDR: begin
				m_phase[8] = data[0];
				if (data[1]) begin
					m_cap  = '0;
					m_done = 1'b0;
				end
			end
			default: begin
			end
		endcase
		if (rs >= 0 && rs < 4)
			m_samples[8*rs +: 8] = data;
		if (ro >= 0 && ro < 4)
			m_offset[8*ro +: 8] = data;
		if (m_settings[SET_RESET_BIT])
			clear_model();
	endtask

	task automatic read_reg(input reg_addr_t addr, input byte_t exp, input string name);
		rx_q.delete();
		host_q.push_back({2'b10, addr});
		while (host_q.size() != 0)
			tick();
		while (cmdfifo_isout_o)
			tick();
		compare($sformatf("%s 0x%0h byte count", name, addr), 1, rx_q.size());
		if (rx_q.size() == 1) begin
			compare($sformatf("%s 0x%0h", name, addr), exp, rx_q[0]);
			compare($sformatf("%s 0x%0h latency", name, addr), 3, wr_cyc - pop_cyc);
		end
	endtask

	task automatic check_outputs();
		compare("gain_o", m_gain, gain_o);
		compare("maxsamples_o", m_samples, maxsamples_o);
		compare("trigger_offset_o", m_offset, trigger_offset_o);
		compare("phase_o level", m_phase, phase_o);
		compare("settings outputs",
			{m_settings[SET_CLKSRC_BIT], m_settings[SET_TRIGWAIT_BIT], m_settings[SET_ARM_BIT],
			 m_settings[SET_TRIGMODE_BIT], m_settings[SET_HILOW_BIT]},
			{adc_clk_src_o, trigger_wait_o, cmd_arm_o, trigger_mode_o, hilow_o});
	endtask

	// Sync byte first, then every sample in order, under random back-pressure
	task automatic dump_fifo(input int n);
		byte_t exp_q[$];
		byte_t b;
		exp_q.push_back(SYNC_BYTE);
		for (int i = 0; i < n; i++) begin
			b = byte_t'($random(seed));
			smp_q.push_back(b);
			exp_q.push_back(b);
		end
		rx_q.delete();
		txe_gaps = 1'b1;
		host_q.push_back({2'b10, ADCDATA_ADDR});
		while (host_q.size() != 0)
			tick();
		while (cmdfifo_isout_o)
			tick();
		txe_gaps = 1'b0;
		compare($sformatf("dump of %0d length", n), exp_q.size(), rx_q.size());
		if (rx_q.size() == exp_q.size()) begin
			foreach (exp_q[i])
				compare($sformatf("dump of %0d byte %0d", n, i), exp_q[i], rx_q[i]);
		end
		if (smp_q.size() != 0) begin
			errors++;
			$display("Sample FIFO still holds %0d bytes after the dump", smp_q.size());
		end
	endtask

	// Hang guard
	initial begin
		repeat (CYCLE_LIMIT) @(posedge ftdi_clk);
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Verification failed");
		$finish;
	end

	initial begin : main
		int        idx;
		reg_addr_t addr;
		byte_t     data;
		word_t     old_freq;
		phase_t    pv;
		seed        = 47;
		errors      = 0;
		checks      = 0;
		cyc         = 0;
		pop_cyc     = 0;
		wr_cyc      = 0;
		ld_pulses   = 0;
		soft_pulses = 0;
		cmd_pop     = 1'b0;
		smp_pop     = 1'b0;
		txe_gaps    = 1'b0;
		done_pulse  = 1'b0;
		rst_v       = 1'b1;
		maxs_v      = word_t'($random(seed));
		status_v    = byte_t'($random(seed));
		freq_v      = word_t'($random(seed));
		phase_v     = '0;

		reset_i            = 1'b1;
		cmdfifo_rxf_i      = 1'b0;
		cmdfifo_txe_i      = 1'b1;
		cmdfifo_din_i      = 8'h00;
		status_i           = status_v;
		fifo_empty_i       = 1'b1;
		fifo_data_i        = 8'h00;
		extclk_frequency_i = freq_v;
		phase_i            = '0;
		phase_done_i       = 1'b0;
		maxsamples_i       = maxs_v;  // Held for the whole run

		addr_list = '{GAIN_ADDR, SETTINGS_ADDR, ECHO_ADDR,
			SAMPLES_ADDR, SAMPLES_ADDR + 6'd1, SAMPLES_ADDR + 6'd2, SAMPLES_ADDR + 6'd3,
			OFFSET_ADDR, OFFSET_ADDR + 6'd1, OFFSET_ADDR + 6'd2, OFFSET_ADDR + 6'd3,
			STATUS_ADDR};
		clear_model();

		// Reset defaults
		repeat (10) tick();
		rst_v = 1'b0;
		tick();
		tick();
		compare("reset controls", 0,
			{cmd_arm_o, phase_ld_o, fifo_rd_en_o, cmdfifo_isout_o, cmdfifo_wr_o, cmdfifo_rd_o});
		for (int k = 0; k < 11; k++)
			read_reg(addr_list[k], model_read(addr_list[k]), "reset read");

		// Random writes and reads
		for (int i = 0; i < N_RANDOM; i++) begin
			idx  = $unsigned($random(seed)) % 11;
			addr = addr_list[idx];
			data = byte_t'($random(seed));
			if (addr == SETTINGS_ADDR)
				data[SET_RESET_BIT] = 1'b0;
			write_reg(addr, data);
			check_outputs();
			if (i % 8 == 0)
				status_v = byte_t'($random(seed));
			idx = $unsigned($random(seed)) % 12;
			read_reg(addr_list[idx], model_read(addr_list[idx]), "random read");
		end
		for (int k = 0; k < 12; k++)
			read_reg(addr_list[k], model_read(addr_list[k]), "sweep read");

		// Frequency snapshot holds across the four byte reads
		freq_v = word_t'($random(seed));
		tick();
		tick();
		old_freq = freq_v;
		read_reg(EXTFREQ_ADDR, old_freq[7:0], "freq locked");
		freq_v = word_t'($random(seed));
		for (int k = 1; k < 4; k++)
			read_reg(reg_addr_t'(int'(EXTFREQ_ADDR) + k), old_freq[8*k +: 8], "freq locked");
		for (int k = 0; k < 4; k++)
			read_reg(reg_addr_t'(int'(EXTFREQ_ADDR) + k), freq_v[8*k +: 8], "freq new");

		// Phase load and capture
		pv        = phase_t'($random(seed));
		ld_pulses = 0;
		write_reg(PHASE_LO_ADDR, pv[7:0]);
		write_reg(PHASE_HI_ADDR, {6'd0, 1'b1, pv[8]});
		tick();
		compare("phase_o", pv, phase_o);
		compare("phase load pulses", 1, ld_pulses);
		phase_v    = phase_t'($random(seed));
		done_pulse = 1'b1;
		tick();
		tick();
		m_cap  = phase_v;
		m_done = 1'b1;
		read_reg(PHASE_LO_ADDR, model_read(PHASE_LO_ADDR), "phase capture");
		read_reg(PHASE_HI_ADDR, model_read(PHASE_HI_ADDR), "phase capture");

		// ADC dumps
		for (int d = 0; d < N_DUMPS; d++)
			dump_fifo($unsigned($random(seed)) % (MAX_DUMP + 1));
		read_reg(ECHO_ADDR, model_read(ECHO_ADDR), "read after dump");

		// Soft reset from settings bit 0
		write_reg(OFFSET_ADDR + 6'd2, byte_t'($random(seed)) | 8'h80);
		write_reg(SETTINGS_ADDR, (byte_t'($random(seed)) & 8'hFE) | 8'h08);
		soft_pulses = 0;
		write_reg(SETTINGS_ADDR, byte_t'($random(seed)) | 8'h01);
		tick();
		compare("soft reset pulses", 1, soft_pulses);
		check_outputs();
		read_reg(SETTINGS_ADDR, 8'h00, "after soft reset");
		for (int k = 0; k < 4; k++)
			read_reg(OFFSET_ADDR + 6'(k), 8'h00, "after soft reset");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* hdl/cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser
	import usb_pkg::*;
(
	input  logic      ftdi_clk,
	input  logic      rst_i,
	input  logic      rxf_i,
	input  byte_t     din_i,
	input  logic      tx_busy_i,
	output logic      rd_o,
	output logic      wr_stb_o,
	output reg_addr_t wr_addr_o,
	output byte_t     wr_data_o,
	output logic      rd_stb_o,
	output reg_addr_t rd_addr_o,
	output logic      isout_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA_WAIT,
		ST_DATA_TAKE,
		ST_RD_ISSUE,
		ST_WAIT_RESP
	} state_t;

	state_t    state;
	reg_addr_t addr_q;

	// Same address serves both directions
	assign wr_addr_o = addr_q;
	assign rd_addr_o = addr_q;

	always_ff @(posedge ftdi_clk or posedge rst_i) begin
		if (rst_i) begin
			state    <= ST_IDLE;
			rd_o     <= 1'b0;
			wr_stb_o <= 1'b0;
			rd_stb_o <= 1'b0;
			isout_o  <= 1'b0;
		end else begin
			rd_o     <= 1'b0;  // All strobes are single cycle
			wr_stb_o <= 1'b0;
			rd_stb_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rxf_i) begin
						rd_o  <= 1'b1;  // Pop command byte
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (!din_i[CMD_VALID_BIT]) begin
						state <= ST_IDLE;  // Junk byte, drop it
					end else if (din_i[CMD_WRITE_BIT]) begin
						state <= ST_DATA_WAIT;
					end else begin
						isout_o  <= 1'b1;
						rd_stb_o <= 1'b1;
						state    <= ST_RD_ISSUE;
					end
				end
				ST_DATA_WAIT: begin
					if (rxf_i) begin
						rd_o  <= 1'b1;
						state <= ST_DATA_TAKE;
					end
				end
				ST_DATA_TAKE: begin
					wr_stb_o <= 1'b1;
					state    <= ST_IDLE;
				end
				ST_RD_ISSUE: state <= ST_WAIT_RESP;  // Bank answers next cycle
				ST_WAIT_RESP: begin
					if (!tx_busy_i) begin
						isout_o <= 1'b0;
						state   <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Byte capture on the pop cycles
	always_ff @(posedge ftdi_clk) begin
		if (state == ST_ADDR)
			addr_q <= din_i[5:0];
		if (state == ST_DATA_TAKE)
			wr_data_o <= din_i;
	end

endmodule

/* hdl/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank
	import usb_pkg::*;
(
	input  logic      ftdi_clk,
	input  logic      rst_i,
	input  logic      wr_stb_i,
	input  reg_addr_t wr_addr_i,
	input  byte_t     wr_data_i,
	input  logic      rd_stb_i,
	input  reg_addr_t rd_addr_i,
	input  byte_t     status_i,
	input  word_t     extclk_frequency_i,
	input  phase_t    phase_i,
	input  logic      phase_done_i,
	input  word_t     maxsamples_i,
	output logic      resp_stb_o,
	output byte_t     resp_byte_o,
	output logic      dump_stb_o,
	output byte_t     settings_o,
	output byte_t     gain_o,
	output word_t     samples_o,
	output word_t     offset_o,
	output phase_t    phase_o,
	output logic      phase_ld_o
);

	byte_t     echo_q;
	word_t     freq_snap;
	logic      freq_locked;
	phase_t    phase_cap;
	logic      phase_done_q;
	byte_t     rd_byte;
	logic      rd_hit;
	reg_addr_t wr_samp_rel;
	reg_addr_t wr_off_rel;
	reg_addr_t rd_samp_rel;
	reg_addr_t rd_off_rel;
	reg_addr_t rd_freq_rel;

	// Offsets into the four-byte blocks, wrap makes low addresses miss
	assign wr_samp_rel = wr_addr_i - SAMPLES_ADDR;
	assign wr_off_rel  = wr_addr_i - OFFSET_ADDR;
	assign rd_samp_rel = rd_addr_i - SAMPLES_ADDR;
	assign rd_off_rel  = rd_addr_i - OFFSET_ADDR;
	assign rd_freq_rel = rd_addr_i - EXTFREQ_ADDR;

	always_ff @(posedge ftdi_clk or posedge rst_i) begin
		if (rst_i) begin
			gain_o     <= '0;
			settings_o <= '0;
			echo_q     <= '0;
			samples_o  <= maxsamples_i;  // Default to full capture depth
			offset_o   <= '0;
			phase_o    <= '0;
			phase_ld_o <= 1'b0;
		end else begin
			phase_ld_o <= 1'b0;
			if (wr_stb_i) begin
				case (wr_addr_i)
					GAIN_ADDR:     gain_o <= wr_data_i;
					SETTINGS_ADDR: settings_o <= wr_data_i;
					ECHO_ADDR:     echo_q <= wr_data_i;
					PHASE_LO_ADDR: phase_o[7:0] <= wr_data_i;
					PHASE_HI_ADDR: begin
						phase_o[8] <= wr_data_i[0];
						phase_ld_o <= wr_data_i[1];  // Start bit
					end
					default: begin
					end
				endcase
				if (wr_samp_rel < 6'd4)
					samples_o[8*wr_samp_rel[1:0] +: 8] <= wr_data_i;
				if (wr_off_rel < 6'd4)
					offset_o[8*wr_off_rel[1:0] +: 8] <= wr_data_i;
			end
		end
	end

	// Held from the LSB read through byte 2, released by anything else
	always_ff @(posedge ftdi_clk or posedge rst_i) begin
		if (rst_i)
			freq_locked <= 1'b0;
		else if (rd_stb_i)
			freq_locked <= (rd_freq_rel < 6'd3);
	end

	always_ff @(posedge ftdi_clk) begin
		if (!freq_locked)
			freq_snap <= extclk_frequency_i;
	end

	always_ff @(posedge ftdi_clk or posedge rst_i) begin
		if (rst_i) begin
			phase_cap    <= '0;
			phase_done_q <= 1'b0;
		end else if (phase_ld_o) begin
			phase_cap    <= '0;  // New shift in progress
			phase_done_q <= 1'b0;
		end else if (phase_done_i) begin
			phase_cap    <= phase_i;
			phase_done_q <= 1'b1;
		end
	end

	always_comb begin
		rd_byte = '0;
		rd_hit  = 1'b1;
		if (rd_samp_rel < 6'd4) begin
			rd_byte = samples_o[8*rd_samp_rel[1:0] +: 8];
		end else if (rd_off_rel < 6'd4) begin
			rd_byte = offset_o[8*rd_off_rel[1:0] +: 8];
		end else if (rd_freq_rel < 6'd4) begin
			rd_byte = freq_snap[8*rd_freq_rel[1:0] +: 8];
		end else begin
			case (rd_addr_i)
				GAIN_ADDR:     rd_byte = gain_o;
				SETTINGS_ADDR: rd_byte = settings_o;
				STATUS_ADDR:   rd_byte = status_i;
				ECHO_ADDR:     rd_byte = echo_q;
				PHASE_LO_ADDR: rd_byte = phase_cap[7:0];
				PHASE_HI_ADDR: rd_byte = {6'd0, phase_done_q, phase_cap[8]};
				ADCDATA_ADDR:  rd_hit = 1'b0;  // Goes out as a dump instead
				default:       rd_hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge ftdi_clk or posedge rst_i) begin
		if (rst_i) begin
			resp_stb_o <= 1'b0;
			dump_stb_o <= 1'b0;
		end else begin
			resp_stb_o <= rd_stb_i && rd_hit;
			dump_stb_o <= rd_stb_i && (rd_addr_i == ADCDATA_ADDR);
		end
	end

	always_ff @(posedge ftdi_clk) begin
		if (rd_stb_i)
			resp_byte_o <= rd_byte;
	end

endmodule

/* hdl/tx_streamer.sv */
`timescale 1ns/1ps

module tx_streamer
	import usb_pkg::*;
(
	input  logic  ftdi_clk,
	input  logic  rst_i,
	input  logic  resp_stb_i,
	input  byte_t resp_byte_i,
	input  logic  dump_stb_i,
	input  logic  txe_i,
	input  logic  fifo_empty_i,
	input  byte_t fifo_data_i,
	output logic  wr_o,
	output byte_t dout_o,
	output logic  fifo_rd_en_o,
	output logic  busy_o
);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DUMP_WR,  // Hold byte until host has room
		TX_DUMP_LD   // Popped sample arrives
	} tx_state_t;

	tx_state_t state;
	logic      resp_wr_q;
	logic      dump_go;

	assign dump_go = (state == TX_DUMP_WR) && txe_i;

	// Register reads ignore txe, dump bytes wait for it
	assign wr_o         = resp_wr_q | dump_go;
	assign fifo_rd_en_o = dump_go && !fifo_empty_i;

	// Covers the gap before the bank strobe turns into state
	assign busy_o = resp_stb_i | dump_stb_i | resp_wr_q | (state != TX_IDLE);

	always_ff @(posedge ftdi_clk or posedge rst_i) begin
		if (rst_i) begin
			state     <= TX_IDLE;
			resp_wr_q <= 1'b0;
		end else begin
			resp_wr_q <= resp_stb_i;
			case (state)
				TX_IDLE: begin
					if (dump_stb_i)
						state <= TX_DUMP_WR;
				end
				TX_DUMP_WR: begin
					if (txe_i) begin
						if (fifo_empty_i)
							state <= TX_IDLE;  // Last byte just went out
						else
							state <= TX_DUMP_LD;
					end
				end
				TX_DUMP_LD: state <= TX_DUMP_WR;
				default:    state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge ftdi_clk) begin
		if (resp_stb_i)
			dout_o <= resp_byte_i;
		else if (dump_stb_i)
			dout_o <= SYNC_BYTE;
		else if (state == TX_DUMP_LD)
			dout_o <= fifo_data_i;  // Valid one cycle after the pop
	end

endmodule

/* hdl/usb_interface.sv */
`timescale 1ns/1ps

module usb_interface
	import usb_pkg::*;
(
	input  logic   ftdi_clk,
	input  logic   reset_i,
	output logic   reset_o,
	input  logic   cmdfifo_rxf_i,
	input  logic   cmdfifo_txe_i,
	input  byte_t  cmdfifo_din_i,
	output logic   cmdfifo_rd_o,
	output logic   cmdfifo_wr_o,
	output byte_t  cmdfifo_dout_o,
	output logic   cmdfifo_isout_o,
	input  byte_t  status_i,
	input  logic   fifo_empty_i,
	input  byte_t  fifo_data_i,
	output logic   fifo_rd_en_o,
	input  word_t  extclk_frequency_i,
	input  phase_t phase_i,
	input  logic   phase_done_i,
	input  word_t  maxsamples_i,
	output byte_t  gain_o,
	output logic   hilow_o,
	output logic   trigger_mode_o,
	output logic   cmd_arm_o,
	output logic   trigger_wait_o,
	output logic   adc_clk_src_o,
	output word_t  trigger_offset_o,
	output word_t  maxsamples_o,
	output phase_t phase_o,
	output logic   phase_ld_o
);

	logic      rst;
	logic      soft_rst_q;
	byte_t     settings;
	logic      wr_stb;
	reg_addr_t wr_addr;
	byte_t     wr_data;
	logic      rd_stb;
	reg_addr_t rd_addr;
	logic      resp_stb;
	byte_t     resp_byte;
	logic      dump_stb;
	logic      tx_busy;

	// Settings bit 0 resets the whole block for one cycle
	always_ff @(posedge ftdi_clk or posedge reset_i) begin
		if (reset_i)
			soft_rst_q <= 1'b0;
		else
			soft_rst_q <= settings[SET_RESET_BIT];
	end

	assign rst     = reset_i | soft_rst_q;
	assign reset_o = rst;

	assign hilow_o        = settings[SET_HILOW_BIT];
	assign trigger_mode_o = settings[SET_TRIGMODE_BIT];
	assign cmd_arm_o      = settings[SET_ARM_BIT];
	assign trigger_wait_o = settings[SET_TRIGWAIT_BIT];
	assign adc_clk_src_o  = settings[SET_CLKSRC_BIT];

	cmd_parser cmd_parser_inst (
		.ftdi_clk  (ftdi_clk),
		.rst_i     (rst),
		.rxf_i     (cmdfifo_rxf_i),
		.din_i     (cmdfifo_din_i),
		.tx_busy_i (tx_busy),
		.rd_o      (cmdfifo_rd_o),
		.wr_stb_o  (wr_stb),
		.wr_addr_o (wr_addr),
		.wr_data_o (wr_data),
		.rd_stb_o  (rd_stb),
		.rd_addr_o (rd_addr),
		.isout_o   (cmdfifo_isout_o)
	);

	reg_bank reg_bank_inst (
		.ftdi_clk           (ftdi_clk),
		.rst_i              (rst),
		.wr_stb_i           (wr_stb),
		.wr_addr_i          (wr_addr),
		.wr_data_i          (wr_data),
		.rd_stb_i           (rd_stb),
		.rd_addr_i          (rd_addr),
		.status_i           (status_i),
		.extclk_frequency_i (extclk_frequency_i),
		.phase_i            (phase_i),
		.phase_done_i       (phase_done_i),
		.maxsamples_i       (maxsamples_i),
		.resp_stb_o         (resp_stb),
		.resp_byte_o        (resp_byte),
		.dump_stb_o         (dump_stb),
		.settings_o         (settings),
		.gain_o             (gain_o),
		.samples_o          (maxsamples_o),
		.offset_o           (trigger_offset_o),
		.phase_o            (phase_o),
		.phase_ld_o         (phase_ld_o)
	);

	tx_streamer tx_streamer_inst (
		.ftdi_clk     (ftdi_clk),
		.rst_i        (rst),
		.resp_stb_i   (resp_stb),
		.resp_byte_i  (resp_byte),
		.dump_stb_i   (dump_stb),
		.txe_i        (cmdfifo_txe_i),
		.fifo_empty_i (fifo_empty_i),
		.fifo_data_i  (fifo_data_i),
		.wr_o         (cmdfifo_wr_o),
		.dout_o       (cmdfifo_dout_o),
		.fifo_rd_en_o (fifo_rd_en_o),
		.busy_o       (tx_busy)
	);

endmodule

/* hdl/usb_pkg.sv */
package usb_pkg;

	typedef logic [7:0]  byte_t;      // Host bus byte
	typedef logic [5:0]  reg_addr_t;
	typedef logic [31:0] word_t;      // Multi-byte registers
	typedef logic [8:0]  phase_t;

	// Single-byte registers
	localparam reg_addr_t GAIN_ADDR     = 6'd0;
	localparam reg_addr_t SETTINGS_ADDR = 6'd1;
	localparam reg_addr_t STATUS_ADDR   = 6'd2;
	localparam reg_addr_t ADCDATA_ADDR  = 6'd3;
	localparam reg_addr_t ECHO_ADDR     = 6'd4;

	// Four-byte blocks, LSB at the base address
	localparam reg_addr_t EXTFREQ_ADDR  = 6'd5;
	localparam reg_addr_t SAMPLES_ADDR  = 6'd16;
	localparam reg_addr_t OFFSET_ADDR   = 6'd26;

	// Phase shifter, bit 8 and load/done live in the high byte
	localparam reg_addr_t PHASE_LO_ADDR = 6'd9;
	localparam reg_addr_t PHASE_HI_ADDR = 6'd10;

	// Command byte layout
	localparam logic [2:0] CMD_VALID_BIT = 3'd7;
	localparam logic [2:0] CMD_WRITE_BIT = 3'd6;  // 1 = write, 0 = read

	localparam byte_t SYNC_BYTE = 8'hAC;  // Leads every ADC dump

	// Settings register fields
	localparam logic [2:0] SET_RESET_BIT    = 3'd0;
	localparam logic [2:0] SET_HILOW_BIT    = 3'd1;
	localparam logic [2:0] SET_TRIGMODE_BIT = 3'd2;
	localparam logic [2:0] SET_ARM_BIT      = 3'd3;
	localparam logic [2:0] SET_TRIGWAIT_BIT = 3'd5;
	localparam logic [2:0] SET_CLKSRC_BIT   = 3'd6;

endpackage

/* run_sim.sh */
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module usb_interface_tb \
	-o usb_interface_sim > build.log 2>&1 \
	&& ./obj_dir/usb_interface_sim > sim.log 2>&1 \
	|| { cat build.log; echo "Build or run of the simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1

/* sim.f */
hdl/usb_pkg.sv
hdl/cmd_parser.sv
hdl/reg_bank.sv
hdl/tx_streamer.sv
hdl/usb_interface.sv
bench/tb_clock.sv
bench/usb_interface_tb.sv
